// File: common/isaPkg.sv
package isaPkg;

    // base widths of the 16-bit isa
    localparam int WORD_W     = 16;
    localparam int REG_ADDR_W = 4;
    localparam int OPCODE_W   = 4;
    localparam int COND_W     = 3;   // ccc field, instr[11:9]
    localparam int NUM_REGS   = 16;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [WORD_W-1:0]     instr_t;
    typedef logic [REG_ADDR_W-1:0] regAddr_t;
    typedef logic [OPCODE_W-1:0]   opcode_t;
    typedef logic [COND_W-1:0]     cond_t;

    // opcodes, instr[15:12]
    localparam opcode_t OP_ADD = 4'h0;
    localparam opcode_t OP_SUB = 4'h1;
    localparam opcode_t OP_XOR = 4'h2;
    localparam opcode_t OP_AND = 4'h3;
    localparam opcode_t OP_OR  = 4'h4;
    localparam opcode_t OP_SLL = 4'h5;
    localparam opcode_t OP_SRL = 4'h6;
    localparam opcode_t OP_SRA = 4'h7;
    localparam opcode_t OP_LW  = 4'h8;
    localparam opcode_t OP_SW  = 4'h9;
    localparam opcode_t OP_LLB = 4'hA;
    localparam opcode_t OP_LHB = 4'hB;
    localparam opcode_t OP_B   = 4'hC;
    localparam opcode_t OP_BR  = 4'hD;
    localparam opcode_t OP_PCS = 4'hE;
    localparam opcode_t OP_HLT = 4'hF;

    // branch conditions
    localparam cond_t COND_NE = 3'b000;
    localparam cond_t COND_EQ = 3'b001;
    localparam cond_t COND_GT = 3'b010;
    localparam cond_t COND_LT = 3'b011;
    localparam cond_t COND_GE = 3'b100;
    localparam cond_t COND_LE = 3'b101;
    localparam cond_t COND_OV = 3'b110;
    localparam cond_t COND_AL = 3'b111;

    localparam instr_t NOP_INSTR = 16'h0000;   // add r0, r0, r0

endpackage

// File: common/pipelinePkg.sv
package pipelinePkg;

    // execute bundle {pcSwitch, aluSrc, regDst, opcode}
    typedef logic [6:0] exCtrl_t;
    localparam int EX_PCSWITCH = 6;
    localparam int EX_ALUSRC   = 5;
    localparam int EX_REGDST   = 4;
    localparam int EX_OP_MSB   = 3;
    localparam int EX_OP_LSB   = 0;

    // memory bundle {memRead, memWrite}
    typedef logic [1:0] memCtrl_t;
    localparam int MEM_READ  = 1;
    localparam int MEM_WRITE = 0;

    // writeback bundle {memToReg, regWrite}
    typedef logic [1:0] wbCtrl_t;
    localparam int WB_MEMTOREG = 1;
    localparam int WB_REGWRITE = 0;

    // memToReg without regWrite only ever comes from hlt
    localparam wbCtrl_t WB_HALT_MARK = 2'b10;

    // alu flags {zero, overflow, negative}
    typedef logic [2:0] flags_t;
    localparam int FLAG_ZERO = 2;
    localparam int FLAG_OVF  = 1;
    localparam int FLAG_NEG  = 0;

endpackage

// File: decode/controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
    input  isaPkg::opcode_t opcode,
    output logic            regDst,
    output logic            aluSrc,
    output logic            memToReg,
    output logic            regWrite,
    output logic            memRead,
    output logic            memWrite,
    output logic            memHalf,
    output logic            branch,
    output logic            branchReg,
    output logic            pcSwitch
);
    import isaPkg::*;

    always_comb begin
        regDst    = 1'b0;   // alu format, result in rd, flags update
        aluSrc    = 1'b0;
        memToReg  = 1'b0;
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        memHalf   = 1'b0;
        branch    = 1'b0;
        branchReg = 1'b0;
        pcSwitch  = 1'b0;
        case (opcode)
            OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_OR: begin
                regDst   = 1'b1;
                regWrite = 1'b1;
            end
            OP_SLL, OP_SRL, OP_SRA: begin
                regDst   = 1'b1;
                aluSrc   = 1'b1;   // shift by immediate
                regWrite = 1'b1;
            end
            OP_LW: begin
                aluSrc   = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
            end
            OP_SW: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            OP_LLB, OP_LHB: begin
                aluSrc   = 1'b1;
                memHalf  = 1'b1;
                regWrite = 1'b1;
            end
            OP_B:   branch = 1'b1;
            OP_BR: begin
                branch    = 1'b1;
                branchReg = 1'b1;
            end
            OP_PCS: begin
                pcSwitch = 1'b1;
                regWrite = 1'b1;
            end
            default: memToReg = 1'b1;   // hlt marker, no regWrite
        endcase
    end

endmodule

// File: decode/branchUnit.sv
`timescale 1ns/100ps

module branchUnit (
    input  isaPkg::cond_t       condition,
    input  pipelinePkg::flags_t flags,
    input  logic                branch,
    input  logic                branchReg,
    input  logic [8:0]          offset,
    input  isaPkg::word_t       branchRegData,
    input  isaPkg::word_t       pcIn,
    output isaPkg::word_t       pcOut,
    output logic                branchTake
);
    import isaPkg::*;
    import pipelinePkg::*;

    logic  z, v, n;
    logic  condMet;
    word_t pcPlus2;

    assign z = flags[FLAG_ZERO];
    assign v = flags[FLAG_OVF];
    assign n = flags[FLAG_NEG];

    always_comb begin
        case (condition)
            COND_NE: condMet = ~z;
            COND_EQ: condMet = z;
            COND_GT: condMet = ~z & ~n;
            COND_LT: condMet = n;
            COND_GE: condMet = z | ~n;
            COND_LE: condMet = z | n;
            COND_OV: condMet = v;
            default: condMet = 1'b1;   // always
        endcase
    end

    assign branchTake = branch & condMet;

    assign pcPlus2 = pcIn + 16'd2;
    // br jumps to the register, b is relative to pc+2
    assign pcOut = branchReg ? branchRegData : pcPlus2 + {{6{offset[8]}}, offset, 1'b0};

endmodule

// File: decode/registerFile.sv
`timescale 1ns/100ps

module registerFile (
    input  logic             clk,
    input  logic             reset,
    input  isaPkg::regAddr_t srcReg1,
    input  isaPkg::regAddr_t srcReg2,
    input  isaPkg::regAddr_t dstReg,
    input  logic             writeReg,
    input  isaPkg::word_t    dstData,
    output isaPkg::word_t    srcData1,
    output isaPkg::word_t    srcData2
);
    import isaPkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset)
            regs <= '{default: '0};
        else if (writeReg && dstReg != '0)   // r0 stays zero
            regs[dstReg] <= dstData;
    end

    // same-cycle write passes through to the reads
    assign srcData1 = (srcReg1 == '0) ? '0 :
                      (writeReg && dstReg == srcReg1) ? dstData : regs[srcReg1];
    assign srcData2 = (srcReg2 == '0) ? '0 :
                      (writeReg && dstReg == srcReg2) ? dstData : regs[srcReg2];

endmodule

// File: decode/cpuID.sv
`timescale 1ns/100ps

module cpuID (
    input  logic                  clk,
    input  logic                  reset,
    input  isaPkg::word_t         pcD,
    input  isaPkg::instr_t        instrD,
    input  pipelinePkg::flags_t   flags,
    input  isaPkg::word_t         wrData,
    input  isaPkg::regAddr_t      regWriteAddress,
    input  logic                  regWrite,
    output logic                  branchTake,
    output isaPkg::word_t         pcBranch,
    output isaPkg::word_t         regAData,
    output isaPkg::word_t         regBData,
    output isaPkg::word_t         immEx,
    output isaPkg::word_t         pcE,
    output isaPkg::regAddr_t      dstRegE,
    output pipelinePkg::exCtrl_t  exControls,
    output pipelinePkg::memCtrl_t memControls,
    output pipelinePkg::wbCtrl_t  wbControls
);
    import isaPkg::*;
    import pipelinePkg::*;

    opcode_t  opcode;
    regAddr_t fieldA, fieldB, fieldC;
    regAddr_t srcSel1, srcSel2;
    word_t    rfData1, rfData2;
    word_t    immNext;
    logic     squash;
    logic     regDstD, aluSrcD, memToRegD, regWriteD, memReadD, memWriteD;
    logic     memHalfD, branchD, branchRegD, pcSwitchD;

    assign opcode = instrD[15:12];
    assign fieldA = instrD[11:8];   // rd / rt, always the destination
    assign fieldB = instrD[7:4];    // rs, base, br target reg
    assign fieldC = instrD[3:0];    // rt or 4-bit immediate

    controlUnit ctrl_i (
        .opcode    (opcode),
        .regDst    (regDstD),
        .aluSrc    (aluSrcD),
        .memToReg  (memToRegD),
        .regWrite  (regWriteD),
        .memRead   (memReadD),
        .memWrite  (memWriteD),
        .memHalf   (memHalfD),
        .branch    (branchD),
        .branchReg (branchRegD),
        .pcSwitch  (pcSwitchD)
    );

    // llb/lhb need the old rd, sw needs the store data
    assign srcSel2 = (memHalfD || memWriteD) ? fieldA : fieldB;
    assign srcSel1 = memWriteD ? fieldB : fieldC;   // sw base moves to port 1

    registerFile regs_i (
        .clk      (clk),
        .reset    (reset),
        .srcReg1  (srcSel1),
        .srcReg2  (srcSel2),
        .dstReg   (regWriteAddress),
        .writeReg (regWrite),
        .dstData  (wrData),
        .srcData1 (rfData1),
        .srcData2 (rfData2)
    );

    branchUnit branch_i (
        .condition     (instrD[11:9]),
        .flags         (flags),
        .branch        (branchD),
        .branchReg     (branchRegD),
        .offset        (instrD[8:0]),
        .branchRegData (rfData2),        // br reads rs through port 2
        .pcIn          (pcD),
        .pcOut         (pcBranch),
        .branchTake    (branchTake)
    );

    always_comb begin
        if (memReadD || memWriteD)
            immNext = {{11{fieldC[3]}}, fieldC, 1'b0};   // word offset
        else if (memHalfD)
            immNext = {8'h00, instrD[7:0]};              // byte for llb/lhb
        else
            immNext = {{12{fieldC[3]}}, fieldC};         // shift amount
    end

    // branches and nops carry no work past decode
    assign squash = branchD || (instrD == NOP_INSTR);

    // decode/execute register, control part
    always_ff @(posedge clk) begin
        if (reset) begin
            exControls  <= '0;
            memControls <= '0;
            wbControls  <= '0;
        end else begin
            exControls  <= squash ? '0 : {pcSwitchD, aluSrcD, regDstD, opcode};
            memControls <= squash ? '0 : {memReadD, memWriteD};
            wbControls  <= squash ? '0 : {memToRegD, regWriteD};
        end
    end

    // payload
    always_ff @(posedge clk) begin
        regAData <= rfData1;
        regBData <= rfData2;
        immEx    <= immNext;
        pcE      <= pcD;
        dstRegE  <= fieldA;
    end

endmodule

// File: hdl/cpuIF.sv
`timescale 1ns/100ps

module cpuIF (
    input  logic           clk,
    input  logic           reset,
    input  logic           branchTake,
    input  isaPkg::word_t  pcBranch,
    input  isaPkg::instr_t instrData,
    output isaPkg::word_t  instrAddr,
    output isaPkg::word_t  pcD,
    output isaPkg::instr_t instrD
);
    import isaPkg::*;

    word_t   pc;
    word_t   pcNext;
    opcode_t fetchOp;

    assign fetchOp   = instrData[15:12];
    assign instrAddr = pc;   // imem answers in the same cycle

    always_comb begin
        if (branchTake)
            pcNext = pcBranch;          // redirect from decode wins
        else if (fetchOp == OP_HLT)
            pcNext = pc;                // park on the hlt
        else
            pcNext = pc + 16'd2;
    end

    // pc and fetch/decode register
    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= '0;
            pcD    <= '0;
            instrD <= NOP_INSTR;
        end else begin
            pc     <= pcNext;
            pcD    <= pc;
            instrD <= branchTake ? NOP_INSTR : instrData;  // wrong-path slot becomes a bubble
        end
    end

endmodule

// File: hdl/cpuEX.sv
`timescale 1ns/100ps

module cpuEX (
    input  logic                  clk,
    input  logic                  reset,
    input  isaPkg::word_t         regAData,
    input  isaPkg::word_t         regBData,
    input  isaPkg::word_t         immEx,
    input  isaPkg::word_t         pcE,
    input  isaPkg::regAddr_t      dstRegE,
    input  pipelinePkg::exCtrl_t  exControls,
    input  pipelinePkg::memCtrl_t memControls,
    input  pipelinePkg::wbCtrl_t  wbControls,
    output pipelinePkg::flags_t   flags,
    output isaPkg::word_t         aluOutM,
    output isaPkg::word_t         storeDataM,
    output isaPkg::regAddr_t      dstRegM,
    output pipelinePkg::memCtrl_t memControlsM,
    output pipelinePkg::wbCtrl_t  wbControlsM
);
    import isaPkg::*;
    import pipelinePkg::*;

    opcode_t opcode;
    word_t   aluA, aluB;
    word_t   sum, diff;
    word_t   result, aluOut;
    logic    addOvf, subOvf;
    flags_t  flagsNext;

    assign opcode = exControls[EX_OP_MSB:EX_OP_LSB];
    assign aluA   = memControls[MEM_WRITE] ? regAData : regBData;   // sw base on port 1
    assign aluB   = exControls[EX_ALUSRC] ? immEx : regAData;

    assign sum    = aluA + aluB;   // add, lw/sw address
    assign diff   = aluA - aluB;
    assign addOvf = (aluA[15] == aluB[15]) && (sum[15] != aluA[15]);
    assign subOvf = (aluA[15] != aluB[15]) && (diff[15] != aluA[15]);

    always_comb begin
        case (opcode)
            OP_SUB:  result = diff;
            OP_XOR:  result = aluA ^ aluB;
            OP_AND:  result = aluA & aluB;
            OP_OR:   result = aluA | aluB;
            OP_SLL:  result = aluA << aluB[3:0];
            OP_SRL:  result = aluA >> aluB[3:0];
            OP_SRA:  result = word_t'($signed(aluA) >>> aluB[3:0]);
            OP_LLB:  result = {regBData[15:8], immEx[7:0]};   // keep high byte
            OP_LHB:  result = {immEx[7:0], regBData[7:0]};    // keep low byte
            default: result = sum;
        endcase
    end

    assign aluOut = exControls[EX_PCSWITCH] ? pcE + 16'd2 : result;   // pcs

    // z for every alu op, v and n only from add/sub
    always_comb begin
        flagsNext = flags;
        flagsNext[FLAG_ZERO] = (result == '0);
        if (opcode == OP_ADD || opcode == OP_SUB) begin
            flagsNext[FLAG_OVF] = (opcode == OP_ADD) ? addOvf : subOvf;
            flagsNext[FLAG_NEG] = result[15];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flags        <= '0;
            memControlsM <= '0;
            wbControlsM  <= '0;
        end else begin
            if (exControls[EX_REGDST])
                flags <= flagsNext;
            memControlsM <= memControls;
            wbControlsM  <= wbControls;
        end
    end

    // execute/memory payload
    always_ff @(posedge clk) begin
        aluOutM    <= aluOut;
        storeDataM <= regBData;   // sw data read through port 2
        dstRegM    <= dstRegE;
    end

endmodule

// File: hdl/cpuMEM.sv
`timescale 1ns/100ps

module cpuMEM (
    input  logic                  clk,
    input  logic                  reset,
    input  isaPkg::word_t         aluOutM,
    input  isaPkg::word_t         storeDataM,
    input  isaPkg::regAddr_t      dstRegM,
    input  pipelinePkg::memCtrl_t memControlsM,
    input  pipelinePkg::wbCtrl_t  wbControlsM,
    input  isaPkg::word_t         dataRdata,
    output isaPkg::word_t         dataAddr,
    output isaPkg::word_t         dataWdata,
    output logic                  dataRead,
    output logic                  dataWrite,
    output isaPkg::word_t         wrData,
    output isaPkg::regAddr_t      regWriteAddress,
    output logic                  regWrite,
    output logic                  halted
);
    import isaPkg::*;
    import pipelinePkg::*;

    word_t wbValue;

    // data port straight off the execute/memory register
    assign dataAddr  = aluOutM;
    assign dataWdata = storeDataM;
    assign dataRead  = memControlsM[MEM_READ];
    assign dataWrite = memControlsM[MEM_WRITE];   // taken at the edge

    assign wbValue = wbControlsM[WB_MEMTOREG] ? dataRdata : aluOutM;   // load or alu

    always_ff @(posedge clk) begin
        if (reset) begin
            regWrite <= 1'b0;
            halted   <= 1'b0;
        end else begin
            regWrite <= wbControlsM[WB_REGWRITE];
            if (wbControlsM == WB_HALT_MARK)
                halted <= 1'b1;   // sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        wrData          <= wbValue;
        regWriteAddress <= dstRegM;
    end

endmodule

// File: hdl/cpuTop.sv
`timescale 1ns/100ps

module cpuTop (
    input  logic           clk,
    input  logic           reset,
    output isaPkg::word_t  instrAddr,
    input  isaPkg::instr_t instrData,
    output isaPkg::word_t  dataAddr,
    output isaPkg::word_t  dataWdata,
    input  isaPkg::word_t  dataRdata,
    output logic           dataRead,
    output logic           dataWrite,
    output logic           halted
);
    import isaPkg::*;
    import pipelinePkg::*;

    // fetch <-> decode
    word_t    pcD, pcBranch;
    instr_t   instrD;
    logic     branchTake;

    // decode -> execute
    word_t    regAData, regBData, immEx, pcE;
    regAddr_t dstRegE;
    exCtrl_t  exControls;
    memCtrl_t memControls;
    wbCtrl_t  wbControls;
    flags_t   flags;

    // execute -> memory
    word_t    aluOutM, storeDataM;
    regAddr_t dstRegM;
    memCtrl_t memControlsM;
    wbCtrl_t  wbControlsM;

    // writeback into the register file
    word_t    wrData;
    regAddr_t regWriteAddress;
    logic     regWrite;

    cpuIF if_i (
        .clk        (clk),
        .reset      (reset),
        .branchTake (branchTake),
        .pcBranch   (pcBranch),
        .instrData  (instrData),
        .instrAddr  (instrAddr),
        .pcD        (pcD),
        .instrD     (instrD)
    );

    cpuID id_i (
        .clk             (clk),
        .reset           (reset),
        .pcD             (pcD),
        .instrD          (instrD),
        .flags           (flags),
        .wrData          (wrData),
        .regWriteAddress (regWriteAddress),
        .regWrite        (regWrite),
        .branchTake      (branchTake),
        .pcBranch        (pcBranch),
        .regAData        (regAData),
        .regBData        (regBData),
        .immEx           (immEx),
        .pcE             (pcE),
        .dstRegE         (dstRegE),
        .exControls      (exControls),
        .memControls     (memControls),
        .wbControls      (wbControls)
    );

    cpuEX ex_i (
        .clk          (clk),
        .reset        (reset),
        .regAData     (regAData),
        .regBData     (regBData),
        .immEx        (immEx),
        .pcE          (pcE),
        .dstRegE      (dstRegE),
        .exControls   (exControls),
        .memControls  (memControls),
        .wbControls   (wbControls),
        .flags        (flags),
        .aluOutM      (aluOutM),
        .storeDataM   (storeDataM),
        .dstRegM      (dstRegM),
        .memControlsM (memControlsM),
        .wbControlsM  (wbControlsM)
    );

    cpuMEM mem_i (
        .clk             (clk),
        .reset           (reset),
        .aluOutM         (aluOutM),
        .storeDataM      (storeDataM),
        .dstRegM         (dstRegM),
        .memControlsM    (memControlsM),
        .wbControlsM     (wbControlsM),
        .dataRdata       (dataRdata),
        .dataAddr        (dataAddr),
        .dataWdata       (dataWdata),
        .dataRead        (dataRead),
        .dataWrite       (dataWrite),
        .wrData          (wrData),
        .regWriteAddress (regWriteAddress),
        .regWrite        (regWrite),
        .halted          (halted)
    );

endmodule

// File: verif/cpuTbProgram.svh
`ifndef CPU_TB_PROGRAM_SVH
`define CPU_TB_PROGRAM_SVH

// R11 = branch marker 0x00a5, R12 = 0x0300 wrong-path base
// R13 = 0x0100 and R14 = 0x0200 result bases

// opcode plus three nibble fields, covers alu, shift, lw, sw and pcs
function automatic instr_t packFields(opcode_t op, int a, int b, int c);
    return {op, a[3:0], b[3:0], c[3:0]};
endfunction

function automatic instr_t byteInstr(opcode_t op, int rd, int imm);
    return {op, rd[3:0], imm[7:0]};   // llb / lhb
endfunction

function automatic instr_t branchInstr(cond_t cond, int off);
    return {OP_B, cond, off[8:0]};
endfunction

function automatic instr_t regBranchInstr(cond_t cond, int rs);
    return {OP_BR, cond, 1'b0, rs[3:0], 4'h0};
endfunction

task automatic put(instr_t w);
    imem[progLen] = w;
    progLen++;
endtask

task automatic addStore(word_t addr, word_t val, string name);
    storeAddr[numStores] = addr;
    storeVal[numStores]  = val;
    storeName[numStores] = name;
    numStores++;
endtask

// sw plus its table entry, address worked out by hand
task automatic checkedStore(int rt, int rs, int off, word_t addr, word_t val, string name);
    put(packFields(OP_SW, rt, rs, off));
    addStore(addr, val, name);
endtask

task automatic takenCase(cond_t cond, int off, word_t addr, string name);
    put(branchInstr(cond, 1));            // target skips one slot
    put(packFields(OP_SW, 11, 12, 0));    // wrong path, must turn into a bubble
    checkedStore(11, 14, off, addr, 16'h00A5, name);
endtask

task automatic notTakenCase(cond_t cond, int off, word_t addr, string name);
    put(branchInstr(cond, 1));
    checkedStore(11, 14, off, addr, 16'h00A5, name);
endtask

task automatic loadProgram;
    put(byteInstr(OP_LHB, 13, 8'h01));   // slot 0, R13 = 0x0100
    put(byteInstr(OP_LHB, 14, 8'h02));
    put(byteInstr(OP_LHB, 12, 8'h03));
    put(byteInstr(OP_LLB, 1, 8'h34));
    put(byteInstr(OP_LLB, 2, 8'hF0));
    put(byteInstr(OP_LLB, 3, 8'hFF));
    put(byteInstr(OP_LHB, 1, 8'h12));    // R1 = 0x1234
    put(byteInstr(OP_LHB, 2, 8'h7F));    // R2 = 0x7ff0
    put(byteInstr(OP_LHB, 3, 8'h80));    // R3 = 0x80ff
    put(byteInstr(OP_LLB, 11, 8'hA5));
    put(NOP_INSTR);
    put(packFields(OP_ADD, 4, 1, 2));    // slot 11, signed overflow
    put(packFields(OP_SUB, 5, 2, 1));
    put(packFields(OP_XOR, 6, 1, 3));
    put(packFields(OP_AND, 7, 1, 3));
    put(packFields(OP_OR, 8, 1, 3));
    put(packFields(OP_SLL, 9, 1, 4));
    put(packFields(OP_SRL, 10, 3, 4));
    put(packFields(OP_SRA, 15, 3, 4));
    checkedStore(4, 13, 0, 16'h0100, 16'h9224, "add_overflow");
    checkedStore(5, 13, 1, 16'h0102, 16'h6DBC, "sub");
    checkedStore(6, 13, 2, 16'h0104, 16'h92CB, "xor");
    checkedStore(7, 13, 3, 16'h0106, 16'h0034, "and");
    checkedStore(8, 13, 4, 16'h0108, 16'h92FF, "or");
    checkedStore(9, 13, 5, 16'h010A, 16'h2340, "sll");
    checkedStore(10, 13, 6, 16'h010C, 16'h080F, "srl");
    checkedStore(15, 13, 7, 16'h010E, 16'hF80F, "sra");
    put(byteInstr(OP_LLB, 1, 8'hCD));    // slot 27, R1 = 0x12cd
    checkedStore(3, 13, -8, 16'h00F0, 16'h80FF, "lhb_merge");
    checkedStore(6, 14, -1, 16'h01FE, 16'h92CB, "sw_neg_offset");
    put(packFields(OP_LW, 9, 14, -1));   // read back what slot 29 wrote
    put(packFields(OP_LW, 0, 14, -1));   // r0 ignores it
    checkedStore(1, 13, -7, 16'h00F2, 16'h12CD, "llb_merge");
    put(NOP_INSTR);
    checkedStore(9, 13, -6, 16'h00F4, 16'h92CB, "lw_neg_offset");
    checkedStore(0, 13, -5, 16'h00F6, 16'h0000, "r0_write");
    put(packFields(OP_SUB, 0, 1, 1));    // slot 36, z=1 v=0 n=0
    put(NOP_INSTR);
    takenCase(COND_EQ, 0, 16'h0200, "beq_taken");
    takenCase(COND_GE, 1, 16'h0202, "bge_taken");
    notTakenCase(COND_NE, 2, 16'h0204, "bne_not_taken");
    notTakenCase(COND_GT, 3, 16'h0206, "bgt_not_taken");
    put(packFields(OP_SUB, 0, 5, 1));    // slot 48, positive result
    put(NOP_INSTR);
    takenCase(COND_NE, 4, 16'h0208, "bne_taken");
    takenCase(COND_GT, 5, 16'h020A, "bgt_taken");
    notTakenCase(COND_EQ, 6, 16'h020C, "beq_not_taken");
    notTakenCase(COND_LT, 7, 16'h020E, "blt_not_taken");
    notTakenCase(COND_LE, -8, 16'h01F0, "ble_not_taken");
    notTakenCase(COND_OV, -7, 16'h01F2, "bov_not_taken");
    put(packFields(OP_SUB, 0, 1, 5));    // slot 64, negative, no overflow
    put(NOP_INSTR);
    takenCase(COND_LT, -6, 16'h01F4, "blt_taken");
    takenCase(COND_LE, -5, 16'h01F6, "ble_taken");
    notTakenCase(COND_GE, -4, 16'h01F8, "bge_not_taken");
    put(packFields(OP_ADD, 0, 1, 2));    // slot 74, overflow
    put(NOP_INSTR);
    takenCase(COND_OV, -3, 16'h01FA, "bov_taken");
    takenCase(COND_AL, -2, 16'h01FC, "bal_taken");
    put(packFields(OP_PCS, 10, 0, 0));   // slot 82, R10 = 0x00a6
    put(byteInstr(OP_LLB, 7, 8'hB2));    // R7 = byte address of slot 89
    put(NOP_INSTR);
    checkedStore(10, 13, -4, 16'h00F8, 16'h00A6, "pcs");
    put(regBranchInstr(COND_AL, 7));     // slot 86
    put(packFields(OP_SW, 11, 12, 0));
    put(packFields(OP_SW, 11, 12, 1));   // skipped
    checkedStore(11, 13, -3, 16'h00FA, 16'h00A5, "br_target");
    put({OP_HLT, 12'h000});              // slot 90
    put(packFields(OP_SW, 11, 12, 2));   // never fetched
endtask

`endif

// File: verif/cpuTb.sv
`timescale 1ns/100ps

module cpuTb;
    import isaPkg::*;

    localparam int IMEM_WORDS   = 512;
    localparam int DMEM_WORDS   = 512;
    localparam int MAX_STORES   = 32;
    localparam int HALT_TIMEOUT = 1000;   // cycles
    localparam int HALT_WATCH   = 12;

    logic   clk;
    logic   reset;
    word_t  instrAddr;
    instr_t instrData;
    word_t  dataAddr, dataWdata, dataRdata;
    logic   dataRead, dataWrite, halted;

    instr_t imem [IMEM_WORDS];
    word_t  dmem [DMEM_WORDS];
    int     progLen;

    // expected store table filled by the program loader
    word_t  storeAddr [MAX_STORES];
    word_t  storeVal  [MAX_STORES];
    string  storeName [MAX_STORES];
    int     storeCount [MAX_STORES];
    int     numStores;
    int     hitIdx;

    int     valueErrors, strayErrors, otherErrors;

    `include "cpuTbProgram.svh"

    cpuTop dut_i (
        .clk       (clk),
        .reset     (reset),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataRdata (dataRdata),
        .dataRead  (dataRead),
        .dataWrite (dataWrite),
        .halted    (halted)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // tightly coupled memories by word index
    assign instrData = imem[instrAddr[9:1]];
    assign dataRdata = dataRead ? dmem[dataAddr[9:1]] : 'x;   // data only while the core reads

    always @(posedge clk) begin
        if (dataWrite)
            dmem[dataAddr[9:1]] <= dataWdata;
    end

    function automatic int findStore(word_t addr);
        for (int i = 0; i < numStores; i++)
            if (storeAddr[i] == addr)
                return i;
        return -1;
    endfunction

    // tally stores per table entry
    always @(posedge clk) begin
        if (!reset && dataWrite) begin
            hitIdx = findStore(dataAddr);
            if (hitIdx >= 0)
                storeCount[hitIdx] <= storeCount[hitIdx] + 1;
        end
    end

    knownStore: assert property (@(posedge clk) disable iff (reset)
        dataWrite |-> findStore(dataAddr) >= 0)
    else begin
        strayErrors++;
        $display("store to address %h (data %h) is not in the expected table",
                 $sampled(dataAddr), $sampled(dataWdata));
    end

    storeData: assert property (@(posedge clk) disable iff (reset)
        (dataWrite && findStore(dataAddr) >= 0) |-> dataWdata == storeVal[findStore(dataAddr)])
    else begin
        valueErrors++;
        $display("** Error %s: expected %h, actual %h",
                 storeName[findStore($sampled(dataAddr))],
                 storeVal[findStore($sampled(dataAddr))], $sampled(dataWdata));
    end

    quietAfterHalt: assert property (@(posedge clk) disable iff (reset)
        halted |-> !dataWrite)
    else begin
        otherErrors++;
        $display("a store happened after the core halted");
    end

    pcFrozen: assert property (@(posedge clk) disable iff (reset)
        halted |=> $stable(instrAddr))
    else begin
        otherErrors++;
        $display("instruction address moved after the core halted");
    end

    initial begin
        int    cycles;
        word_t haltAddr;
        reset       = 1'b1;
        progLen     = 0;
        numStores   = 0;
        valueErrors = 0;
        strayErrors = 0;
        otherErrors = 0;
        void'($urandom(32'h7f4fab0c));
        for (int i = 0; i < DMEM_WORDS; i++)
            dmem[i] = word_t'($urandom());
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = {OP_HLT, 12'h000};   // stray fetch just halts
        for (int i = 0; i < MAX_STORES; i++)
            storeCount[i] = 0;
        loadProgram();

        // fetch parks on the first hlt of the program
        haltAddr = '0;
        for (int i = progLen - 1; i >= 0; i--)
            if (imem[i][15:12] == OP_HLT)
                haltAddr = word_t'(2 * i);

        repeat (16) @(posedge clk);
        // state seen at the last reset edge
        assert (instrAddr == 16'h0000) else begin
            valueErrors++;
            $display("** Error reset_state: instrAddr expected %h, actual %h", 16'h0, instrAddr);
        end
        assert (!dataWrite && !dataRead && !halted) else begin
            valueErrors++;
            $display("** Error reset_state: write/read/halted expected 000, actual %b%b%b",
                     dataWrite, dataRead, halted);
        end
        reset <= 1'b0;

        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end

        if (!halted) begin
            otherErrors++;
            $display("timed out after %0d cycles waiting for halted", HALT_TIMEOUT);
        end else begin
            cycles = 0;
            while (cycles < HALT_WATCH) begin   // assertions watch the idle core
                @(posedge clk);
                cycles++;
            end
            if (instrAddr != haltAddr) begin
                valueErrors++;
                $display("** Error halt_pc: expected %h, actual %h", haltAddr, instrAddr);
            end
            for (int i = 0; i < numStores; i++) begin
                if (storeCount[i] != 1) begin
                    otherErrors++;
                    $display("store %s at %h happened %0d times instead of once",
                             storeName[i], storeAddr[i], storeCount[i]);
                end
            end
        end

        $display("errors: %0d wrong value, %0d stray store, %0d other",
                 valueErrors, strayErrors, otherErrors);
        if (valueErrors + strayErrors + otherErrors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verif
common/isaPkg.sv
common/pipelinePkg.sv
decode/controlUnit.sv
decode/branchUnit.sv
decode/registerFile.sv
decode/cpuID.sv
hdl/cpuIF.sv
hdl/cpuEX.sv
hdl/cpuMEM.sv
hdl/cpuTop.sv
verif/cpuTb.sv

// File: Bender.yml
package:
  name: cpu16

sources:
  - files:
      - common/isaPkg.sv
      - common/pipelinePkg.sv
      - decode/controlUnit.sv
      - decode/branchUnit.sv
      - decode/registerFile.sv
      - decode/cpuID.sv
      - hdl/cpuIF.sv
      - hdl/cpuEX.sv
      - hdl/cpuMEM.sv
      - hdl/cpuTop.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/cpuTb.sv
